// File: verilog/delay_pkg.sv
`default_nettype none

package delay_pkg;

    // ####################
    // sizes of the tap subsystem

    // one audio word as it comes off the I2S line
    localparam int SAMPLE_BITS = 16;

    // ring length, kept a power of two so the index wraps by its own width
    localparam int BUFFER_LENGTH = 32;

    // the lag window swept after every new sample
    localparam int DELTA_START = 4;
    localparam int DELTA_LAST = 12;

    // the far tap lies this many samples behind the near tap
    localparam int TAP_SPACING = 8;

    // ####################
    // shared types

    typedef logic signed [SAMPLE_BITS-1:0] sample_t;

    typedef logic [$clog2(BUFFER_LENGTH)-1:0] ptr_t;

    typedef logic [$clog2(DELTA_LAST + 1)-1:0] delta_t;

endpackage

`default_nettype wire

// File: verilog/i2s_receiver.sv
`default_nettype none

module i2s_receiver
    import delay_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_bclk,
    input  logic    i_lrck,
    input  logic    i_sdata,
    output sample_t o_sample,
    output logic    o_sample_valid
);

    // counts the skipped I2S bit plus the data bits of one word
    typedef logic [$clog2(SAMPLE_BITS + 2)-1:0] bit_cnt_t;

    logic [1:0] bclk_sync;
    logic [1:0] lrck_sync;
    logic [1:0] sdata_sync;
    logic       bclk_prev;
    logic       lrck_prev;
    logic       bclk_rise;
    logic       lrck_rise;
    logic       lrck_fall;
    logic       bit_take;
    bit_cnt_t   bit_cnt;
    logic [1:0] done_pipe;
    sample_t    shift_reg;

    // ####################
    // synchronizers and edge detect

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            bclk_sync  <= '0;
            lrck_sync  <= '0;
            sdata_sync <= '0;
            bclk_prev  <= 1'b0;
            lrck_prev  <= 1'b0;
        end else begin
            bclk_sync  <= {bclk_sync[0], i_bclk};
            lrck_sync  <= {lrck_sync[0], i_lrck};
            sdata_sync <= {sdata_sync[0], i_sdata};
            bclk_prev  <= bclk_sync[1];
            lrck_prev  <= lrck_sync[1];
        end
    end

    assign bclk_rise = bclk_sync[1] & ~bclk_prev;
    assign lrck_rise = lrck_sync[1] & ~lrck_prev;
    assign lrck_fall = ~lrck_sync[1] & lrck_prev;

    // left half only, and stop once the word is complete
    assign bit_take = bclk_rise && !lrck_sync[1] && (bit_cnt <= bit_cnt_t'(SAMPLE_BITS));

    // ####################
    // deserializer

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            // parked at the end so nothing is captured before the first left half
            bit_cnt        <= bit_cnt_t'(SAMPLE_BITS + 1);
            done_pipe      <= '0;
            o_sample_valid <= 1'b0;
        end else begin
            if (lrck_fall) begin
                bit_cnt <= '0;
            end else if (bit_take) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            done_pipe      <= {done_pipe[0], lrck_rise};
            o_sample_valid <= done_pipe[1];
        end
    end

    // bit 0 of the count is the one-bit I2S delay and is thrown away
    always_ff @(posedge i_clk) begin
        if (bit_take && bit_cnt != '0) begin
            shift_reg <= {shift_reg[SAMPLE_BITS-2:0], sdata_sync[1]};
        end
        if (done_pipe[1]) begin
            o_sample <= shift_reg;
        end
    end

endmodule

`default_nettype wire

// File: verilog/delay_line.sv
`default_nettype none

module delay_line
    import delay_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_start,
    input  logic    i_scan_start,
    input  logic    i_sample_valid,
    input  sample_t i_sample,
    input  delta_t  i_delta,
    output sample_t o_near_tap,
    output sample_t o_far_tap
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FILL,
        S_SCAN
    } state_t;

    state_t  state;
    state_t  state_next;
    ptr_t    pointer;
    ptr_t    near_idx;
    ptr_t    far_idx;
    logic    write_en;
    sample_t ring [BUFFER_LENGTH];

    // ####################
    // state and write pointer

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (i_start) begin
                    state_next = S_FILL;
                end
            end
            S_FILL: begin
                if (i_scan_start) begin
                    state_next = S_SCAN;
                end
            end
            default: begin
                state_next = state;
            end
        endcase
    end

    assign write_en = i_sample_valid && (state != S_IDLE);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state   <= S_IDLE;
            pointer <= '0;
        end else begin
            state <= state_next;
            if (state == S_IDLE) begin
                pointer <= '0;
            end else if (write_en) begin
                // wraps modulo BUFFER_LENGTH through the pointer width
                pointer <= pointer + 1'b1;
            end
        end
    end

    // ####################
    // sample ring

    // the ring is wiped every cycle while idle so a new fill starts from zeros
    always_ff @(posedge i_clk) begin
        if (state == S_IDLE) begin
            for (int i = 0; i < BUFFER_LENGTH; i++) begin
                ring[i] <= '0;
            end
        end else if (write_en) begin
            ring[pointer] <= i_sample;
        end
    end

    // ####################
    // tap reads

    // after the last write the pointer sits on the oldest sample,
    // so the smallest lag reads the oldest entry
    assign near_idx = pointer + ptr_t'(i_delta) - ptr_t'(DELTA_START);
    assign far_idx  = near_idx - ptr_t'(TAP_SPACING);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_near_tap <= '0;
            o_far_tap  <= '0;
        end else if (state == S_SCAN) begin
            o_near_tap <= ring[near_idx];
            o_far_tap  <= ring[far_idx];
        end
    end

endmodule

`default_nettype wire

// File: verilog/delay_scan.sv
`default_nettype none

module delay_scan
    import delay_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_start,
    input  logic   i_sample_valid,
    output logic   o_scan_start,
    output delta_t o_delta,
    output delta_t o_tap_delta,
    output logic   o_tap_valid,
    output logic   o_scanning
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FILL,
        S_SCAN
    } state_t;

    state_t state;
    ptr_t   fill_cnt;
    logic   sweep_active;

    // ####################
    // fill counter

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state        <= S_IDLE;
            fill_cnt     <= '0;
            o_scan_start <= 1'b0;
        end else begin
            o_scan_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        state    <= S_FILL;
                        fill_cnt <= '0;
                    end
                end
                S_FILL: begin
                    if (i_sample_valid) begin
                        if (fill_cnt == ptr_t'(BUFFER_LENGTH - 1)) begin
                            state        <= S_SCAN;
                            o_scan_start <= 1'b1;
                        end else begin
                            fill_cnt <= fill_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= state;
                end
            endcase
        end
    end

    assign o_scanning = (state == S_SCAN);

    // ####################
    // lag sweep

    // the sweep steps one lag per cycle and the sample that fills the ring starts none
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            sweep_active <= 1'b0;
            o_delta      <= delta_t'(DELTA_START);
        end else if (sweep_active) begin
            if (o_delta == delta_t'(DELTA_LAST)) begin
                sweep_active <= 1'b0;
            end else begin
                o_delta <= o_delta + 1'b1;
            end
        end else if (state == S_SCAN && i_sample_valid) begin
            sweep_active <= 1'b1;
            o_delta      <= delta_t'(DELTA_START);
        end
    end

    // one register to line up with the buffer read
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_tap_valid <= 1'b0;
            o_tap_delta <= '0;
        end else begin
            o_tap_valid <= sweep_active;
            o_tap_delta <= o_delta;
        end
    end

endmodule

`default_nettype wire

// File: verilog/delay_top.sv
`default_nettype none

module delay_top
    import delay_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_bclk,
    input  logic    i_lrck,
    input  logic    i_sdata,
    input  logic    i_start,
    output delta_t  o_delta,
    output sample_t o_near_tap,
    output sample_t o_far_tap,
    output logic    o_tap_valid,
    output logic    o_scanning
);

    sample_t sample;
    logic    sample_valid;
    logic    scan_start;
    delta_t  delta;

    i2s_receiver u_i2s_receiver (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_bclk         (i_bclk),
        .i_lrck         (i_lrck),
        .i_sdata        (i_sdata),
        .o_sample       (sample),
        .o_sample_valid (sample_valid)
    );

    delay_scan u_delay_scan (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_start        (i_start),
        .i_sample_valid (sample_valid),
        .o_scan_start   (scan_start),
        .o_delta        (delta),
        .o_tap_delta    (o_delta),
        .o_tap_valid    (o_tap_valid),
        .o_scanning     (o_scanning)
    );

    delay_line u_delay_line (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_start        (i_start),
        .i_scan_start   (scan_start),
        .i_sample_valid (sample_valid),
        .i_sample       (sample),
        .i_delta        (delta),
        .o_near_tap     (o_near_tap),
        .o_far_tap      (o_far_tap)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic o_clk,
    output logic o_rst
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 5;
    localparam int RESET_CYCLES = 5;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tb/delay_tb.sv
`default_nettype none

module delay_tb
    import delay_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // clocks per BCLK phase and BCLK periods per half-frame
    localparam int BCLK_HALF = 4;
    localparam int SLOT_BITS = 18;
    localparam int FRAME_CYCLES = 2 * SLOT_BITS * 2 * BCLK_HALF;
    localparam int LAGS = DELTA_LAST - DELTA_START + 1;

    localparam int IDLE_FRAMES = 2;
    localparam int SCAN_FRAMES = 40;
    localparam int RESTART_SCAN_FRAMES = 3;
    localparam int RESET_AFTER_STROBES = 3;
    localparam int TOTAL_FRAMES = IDLE_FRAMES + 2 * BUFFER_LENGTH + SCAN_FRAMES + 2
                                  + RESTART_SCAN_FRAMES;
    // four frames of margin for resets, start pulses and the checks between frames
    localparam int CYCLE_LIMIT = (TOTAL_FRAMES + 4) * FRAME_CYCLES;

    localparam int MODE_OFF = 0;
    localparam int MODE_IDLE = 1;
    localparam int MODE_FILL = 2;
    localparam int MODE_SCAN = 3;

    logic    clk;
    logic    por_rst;
    logic    soft_rst;
    logic    rst;
    logic    bclk;
    logic    lrck;
    logic    sdata;
    logic    start;
    delta_t  tap_delta;
    sample_t near_tap;
    sample_t far_tap;
    logic    tap_valid;
    logic    scanning;

    int      seed;
    int      mode;
    bit      armed;
    int      strobe_count;
    int      sample_count;
    int      cycle_count = 0;
    sample_t hist [$];

    assign rst = por_rst | soft_rst;

    tb_clock clock_gen (
        .o_clk (clk),
        .o_rst (por_rst)
    );

    delay_top DUT (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_bclk      (bclk),
        .i_lrck      (lrck),
        .i_sdata     (sdata),
        .i_start     (start),
        .o_delta     (tap_delta),
        .o_near_tap  (near_tap),
        .o_far_tap   (far_tap),
        .o_tap_valid (tap_valid),
        .o_scanning  (scanning)
    );

    // ####################
    // reference model

    // latest sample written at ring position pos after count writes or zero if none yet
    function automatic sample_t ring_value(input sample_t history[$], input int count,
                                           input int pos);
        int last;
        int k;
        last = count - 1;
        k = last - (((last - pos) % BUFFER_LENGTH) + BUFFER_LENGTH) % BUFFER_LENGTH;
        if (k < 0) begin
            return '0;
        end
        return history[k];
    endfunction

    function automatic void reference_taps(input sample_t history[$], input int count,
                                           input int lag, output sample_t near,
                                           output sample_t far);
        int near_pos;
        int far_pos;
        near_pos = (count + lag - DELTA_START) % BUFFER_LENGTH;
        far_pos = (near_pos - TAP_SPACING + BUFFER_LENGTH) % BUFFER_LENGTH;
        near = ring_value(history, count, near_pos);
        far = ring_value(history, count, far_pos);
    endfunction

    task automatic check_value(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        if (expected !== actual) begin
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // ####################
    // I2S stimulus

    // full-scale words show up regularly among the random ones
    function automatic sample_t next_sample();
        logic [31:0] rnd;
        rnd = $random(seed);
        sample_count++;
        if (sample_count % 13 == 5) begin
            return {1'b0, {(SAMPLE_BITS-1){1'b1}}};
        end else if (sample_count % 13 == 9) begin
            return {1'b1, {(SAMPLE_BITS-1){1'b0}}};
        end
        return sample_t'(rnd[SAMPLE_BITS-1:0]);
    endfunction

    // LRCK and data change together with the BCLK falling edge
    task automatic bclk_period(input logic lr, input logic bit_val);
        @(posedge clk);
        bclk  <= 1'b0;
        lrck  <= lr;
        sdata <= bit_val;
        repeat (BCLK_HALF) @(posedge clk);
        bclk <= 1'b1;
        repeat (BCLK_HALF - 1) @(posedge clk);
    endtask

    task automatic send_frame(input sample_t left);
        logic [31:0]            rnd;
        logic [SAMPLE_BITS-1:0] right;
        rnd = $random(seed);
        right = rnd[SAMPLE_BITS-1:0];
        if (armed) begin
            hist.push_back(left);
        end
        for (int p = 0; p < SLOT_BITS; p++) begin
            bclk_period(1'b0, (p >= 1 && p <= SAMPLE_BITS) ? left[SAMPLE_BITS-p] : 1'b0);
        end
        for (int p = 0; p < SLOT_BITS; p++) begin
            bclk_period(1'b1, (p >= 1 && p <= SAMPLE_BITS) ? right[SAMPLE_BITS-p] : 1'b0);
        end
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        armed = 1'b1;
        mode = MODE_FILL;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic fill_buffer();
        for (int f = 1; f <= BUFFER_LENGTH; f++) begin
            send_frame(next_sample());
            @(negedge clk);
            check_value("o_scanning", (f == BUFFER_LENGTH) ? 1 : 0, scanning);
            @(posedge clk);
        end
        mode = MODE_SCAN;
    endtask

    task automatic scan_frames(input int n_frames);
        for (int f = 0; f < n_frames; f++) begin
            strobe_count = 0;
            send_frame(next_sample());
            @(negedge clk);
            check_value("tap_valid strobes per frame", LAGS, strobe_count);
            @(posedge clk);
        end
    endtask

    initial begin
        seed = 43;
        mode = MODE_OFF;
        armed = 1'b0;
        strobe_count = 0;
        sample_count = 0;
        soft_rst = 1'b0;
        bclk = 1'b1;
        lrck = 1'b1;
        sdata = 1'b0;
        start = 1'b0;

        @(posedge clk);
        while (por_rst) @(posedge clk);
        mode = MODE_IDLE;

        // frames without i_start must leave everything idle
        repeat (IDLE_FRAMES) send_frame(next_sample());

        pulse_start();
        fill_buffer();
        scan_frames(SCAN_FRAMES);

        // reset lands in the middle of a sweep
        strobe_count = 0;
        fork
            send_frame(next_sample());
            begin
                wait (strobe_count == RESET_AFTER_STROBES);
                @(posedge clk);
                soft_rst <= 1'b1;
                mode = MODE_IDLE;
                armed = 1'b0;
                hist.delete();
                repeat (5) @(posedge clk);
                soft_rst <= 1'b0;
            end
        join

        send_frame(next_sample());
        pulse_start();
        fill_buffer();
        scan_frames(RESTART_SCAN_FRAMES);

        $display("All tests passed");
        $finish;
    end

    // ####################
    // compare and timeout

    // outputs change on the rising edge and are sampled on the falling one
    always @(negedge clk) begin
        sample_t exp_near;
        sample_t exp_far;
        case (mode)
            MODE_IDLE: begin
                check_value("o_tap_valid", 0, tap_valid);
                check_value("o_scanning", 0, scanning);
                check_value("o_near_tap", 0, near_tap);
                check_value("o_far_tap", 0, far_tap);
            end
            MODE_FILL: begin
                check_value("o_tap_valid", 0, tap_valid);
                // the taps start to follow the ring once scanning begins
                if (!scanning) begin
                    check_value("o_near_tap", 0, near_tap);
                    check_value("o_far_tap", 0, far_tap);
                end
            end
            MODE_SCAN: begin
                check_value("o_scanning", 1, scanning);
                if (tap_valid) begin
                    reference_taps(hist, hist.size(), DELTA_START + strobe_count,
                                   exp_near, exp_far);
                    check_value("o_delta", DELTA_START + strobe_count, tap_delta);
                    check_value("o_near_tap", exp_near, near_tap);
                    check_value("o_far_tap", exp_far, far_tap);
                    strobe_count++;
                end
            end
            default: begin
            end
        endcase
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $fatal(1, "simulation timed out");
        end
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/delay_pkg.sv
verilog/i2s_receiver.sv
verilog/delay_line.sv
verilog/delay_scan.sv
verilog/delay_top.sv
tb/tb_clock.sv
tb/delay_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the delay tap testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_MSG="All tests passed"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f sim.f --top-module delay_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vdelay_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -qx "$PASS_MSG" "$LOG"
if [ $? -ne 0 ]; then
    echo "pass message not found in $LOG"
    exit 1
fi

echo "simulation passed"
exit 0
